// ==== dv/conv_layer_tb.sv ====
// testbench for the conv layer top; runs the command lines of dv/conv_tests.txt over wishbone
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_layer_tb import conv_pkg::*; ();

	localparam int ACK_LIMIT  = 16;  // cycles per bus access
	localparam int POLL_LIMIT = 400; // status reads per wait, a run needs about 85

	logic    clk;
	logic    arst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [31:0] lfsr;
	pix_t    img_sh  [IMG_WORDS];    // host copy of what the dut should hold
	pix_t    wgt_sh  [WGT_WORDS];
	pix_t    bias_sh [`CONV_CHOUT];
	logic    run_active;             // layer running, dut drops memory writes
	string   cur_test;
	int      n_tests, n_checks, n_errors, test_errors;

	conv_layer_top dut_i (.clk, .arst_n, .wb_req, .wb_rsp);

	always #20 clk = ~clk; // 40 ns period

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// random words and the reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois, shift right
	endfunction

	// 16 bits, one lfsr step each, then masked
	function automatic logic [15:0] rand_word(input logic [15:0] mask);
		logic [15:0] v;
		v = '0;
		for (int b = 0; b < 16; b++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v & mask;
	endfunction

	// window sum plus bias in q4.28, negatives to 0, bits 29:14, saturate above
	function automatic logic [15:0] expect_out(input int idx);
		int     lane, oy, ox;
		longint s;
		lane = idx / OUT_PIX;
		oy   = (idx % OUT_PIX) / `CONV_OUT_W;
		ox   = idx % `CONV_OUT_W;
		s    = longint'(bias_sh[lane]) <<< `CONV_FRAC;
		for (int ch = 0; ch < `CONV_CHIN; ch++)
			for (int ky = 0; ky < `CONV_KDIM; ky++)
				for (int kx = 0; kx < `CONV_KDIM; kx++)
					s += longint'(img_sh[ch * 64 + (oy * 2 + ky) * 8 + ox * 2 + kx])
						* longint'(wgt_sh[lane * `CONV_TAPS + ch * 9 + ky * 3 + kx]);
		if (s < 0)
			return 16'h0000;
		if (s >= (64'sd1 <<< 30))
			return 16'h7fff;
		return s[29:14];
	endfunction

	//////////////////////////////////////////////////
	// bus access, driven on the falling edge
	//////////////////////////////////////////////////
	task automatic bus_cycle(input logic we, input logic [9:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int n;
		@(negedge clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		n = 0;
		do begin
			@(negedge clk); // ack and read data are stable here
			n++;
		end while (!wb_rsp.ack && n < ACK_LIMIT);
		assert (wb_rsp.ack) else abort_run($sformatf("no ack for address %h in %s", adr, cur_test));
		rdat   = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic host_write(input logic [9:0] adr, input logic [15:0] dat);
		logic [31:0] rdat_ignored;
		bus_cycle(1'b1, adr, {16'h0, dat}, rdat_ignored);
		if (!run_active) begin // writes during a run never land
			if (adr >= `CONV_ADR_IMG && adr < `CONV_ADR_IMG + IMG_WORDS)
				img_sh[adr - `CONV_ADR_IMG] = dat;
			else if (adr >= `CONV_ADR_WGT && adr < `CONV_ADR_WGT + WGT_WORDS)
				wgt_sh[adr - `CONV_ADR_WGT] = dat;
			else if (adr >= `CONV_ADR_BIAS && adr < `CONV_ADR_BIAS + `CONV_CHOUT)
				bias_sh[adr - `CONV_ADR_BIAS] = dat;
		end
	endtask

	task automatic expect_read(input logic [9:0] adr, input logic [31:0] exp);
		logic [31:0] got;
		bus_cycle(1'b0, adr, '0, got);
		n_checks++;
		assert (got === exp) else begin
			$display("Mismatch %s adr %h expected %h actual %h", cur_test, adr, exp, got);
			test_errors++;
			n_errors++;
		end
	endtask

	// status polling, bit 0 busy, bit 1 done
	task automatic poll_status(input int bit_idx, input string what);
		logic [31:0] st;
		int          n;
		n = 0;
		do begin
			bus_cycle(1'b0, `CONV_ADR_STAT, '0, st);
			n++;
		end while (!st[bit_idx] && n < POLL_LIMIT);
		assert (st[bit_idx]) else abort_run($sformatf("%s never set in %s", what, cur_test));
	endtask

	task automatic start_layer();
		host_write(`CONV_ADR_CTRL, 16'h0001);
		poll_status(0, "busy");
		run_active = 1'b1;
	endtask

	task automatic fill_region(input string region, input int count, input logic [15:0] mask);
		logic [9:0] base;
		case (region)
			"img":   base = `CONV_ADR_IMG;
			"wgt":   base = `CONV_ADR_WGT;
			"bias":  base = `CONV_ADR_BIAS;
			default: abort_run($sformatf("unknown fill region %s", region));
		endcase
		for (int i = 0; i < count; i++)
			host_write(base + 10'(i), rand_word(mask));
	endtask

	//////////////////////////////////////////////////
	// command loop
	//////////////////////////////////////////////////
	initial begin
		int               fd, r, idx, cnt;
		string            cmd, region;
		logic [31:0]      a, d;
		logic [8*160-1:0] rest;
		clk         = 1'b0;
		arst_n      = 1'b0;
		wb_req      = '0;
		lfsr        = 32'h420b_d6b7;
		run_active  = 1'b0;
		cur_test    = "none";
		n_tests     = 0;
		n_checks    = 0;
		n_errors    = 0;
		test_errors = 0;
		fd = $fopen("dv/conv_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open dv/conv_tests.txt");
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", cmd);
			if (r != 1)
				break;
			case (cmd)
				"test": begin
					r = $fscanf(fd, "%s", cur_test);
					n_tests++;
					test_errors = 0;
				end
				"wr": begin
					r = $fscanf(fd, "%h %h", a, d);
					host_write(a[9:0], d[15:0]);
				end
				"rd": begin
					r = $fscanf(fd, "%h %h", a, d);
					expect_read(a[9:0], d);
				end
				"rdx": begin
					r = $fscanf(fd, "%h", a);
					bus_cycle(1'b0, a[9:0], '0, d); // only the ack matters
					n_checks++;
				end
				"fill": begin
					r = $fscanf(fd, "%s %d %h", region, cnt, d);
					fill_region(region, cnt, d[15:0]);
				end
				"go": start_layer();
				"wait": begin
					poll_status(1, "done");
					run_active = 1'b0;
				end
				"run": begin
					start_layer();
					poll_status(1, "done");
					run_active = 1'b0;
				end
				"chk": begin
					r = $fscanf(fd, "%d %h", idx, d);
					expect_read(`CONV_ADR_OUT + 10'(idx), d);
				end
				"model": begin
					for (int i = 0; i < OUT_WORDS; i++)
						expect_read(`CONV_ADR_OUT + 10'(i), {16'h0, expect_out(i)});
				end
				"end": begin
					if (test_errors == 0)
						$display("test %s: ok", cur_test);
					else
						$display("test %s: %0d errors", cur_test, test_errors);
				end
				default: begin
					if (cmd.substr(0, 0) == "#")
						r = $fgets(rest, fd); // column notes
					else
						abort_run($sformatf("unknown command %s in the tests file", cmd));
				end
			endcase
		end
		$fclose(fd);
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== dv/conv_tests.txt ====
# commands: test <name> | wr <adr> <data> | rd <adr> <expected> | rdx <adr> | go | wait | run
# fill <img|wgt|bias> <count> <mask> | chk <out index> <expected> | model | end
# adr, data, mask and expected are hex; count and out index are decimal
test reset_state
rd 001 00000000
rdx 180
rdx 1a3
end
test single_tap
fill img 128 0000
fill wgt 72 0000
fill bias 4 0000
wr 049 2000
wr 05d 1000
wr 072 3000
wr 0a4 0800
wr 0ac 0123
wr 104 4000
wr 11d 6000
wr 12c 2000
wr 142 4000
run
chk 0 2000
chk 5 1000
chk 16 0c00
chk 24 1800
chk 35 0123
chk 1 0000
model
end
test clamp_saturate
wr 049 8000
wr 104 8000
wr 12c e000
run
chk 0 7fff
chk 5 0000
chk 24 0000
chk 16 0c00
model
end
test bias_only
fill wgt 72 0000
wr 160 0100
wr 161 0abc
wr 162 ff00
wr 163 1234
run
chk 0 0100
chk 8 0100
chk 13 0abc
chk 22 0000
chk 27 1234
chk 35 1234
model
end
test lfsr_fill
fill img 128 07ff
fill wgt 72 ffff
fill bias 4 0fff
run
model
rd 001 00000002
end
test rerun_busy_writes
fill wgt 72 ffff
go
wr 104 7fff
wr 049 7fff
wr 160 7fff
wait
model
rd 001 00000002
end

// ==== flist.f ====
+incdir+include
hw/conv_pkg.sv
hw/conv_wb_slave.sv
hw/conv_mem_bank.sv
hw/layer_ctrl_fsm.sv
hw/window_tap_counter.sv
hw/conv_mac_array.sv
hw/conv_layer_top.sv
dv/conv_layer_tb.sv

// ==== hw/conv_layer_top.sv ====
// conv layer accelerator top, wishbone slave in front of memories, sequencer, tap counter and macs
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_layer_top import conv_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	logic              start, busy, done;
	logic              cnt_en, scan_end;
	logic              mem_we;
	mem_sel_e          mem_sel;
	logic [PIX_AW-1:0] mem_adr;
	pix_t              mem_dat;
	logic [OUT_AW-1:0] out_adr;
	pix_t              out_dat;
	tap_t              tap_cnt;               // from the counter
	tap_t              tap_mem;               // one cycle later, beside the data
	pix_t              pix;
	pix_t              wgt  [`CONV_CHOUT];
	pix_t              bias [`CONV_CHOUT];

	conv_wb_slave slave_i (
		.clk, .arst_n, .wb_req, .wb_rsp, .busy, .done, .start,
		.mem_we, .mem_sel, .mem_adr, .mem_dat, .out_adr, .out_dat
	);

	conv_mem_bank mem_i (
		.clk, .arst_n, .mem_we, .mem_sel, .mem_adr, .mem_dat, .busy,
		.tap_in(tap_cnt), .tap_out(tap_mem), .pix, .wgt, .bias
	);

	layer_ctrl_fsm ctrl_i (
		.clk, .arst_n, .start, .scan_end, .cnt_en, .busy, .done
	);

	window_tap_counter cnt_i (
		.clk, .arst_n, .cnt_en, .tap(tap_cnt), .scan_end
	);

	conv_mac_array mac_i (
		.clk, .arst_n, .tap(tap_mem), .pix, .wgt, .bias, .out_adr, .out_dat
	);

endmodule

// ==== hw/conv_mac_array.sv ====
// one mac lane per output channel, then bias, relu and q2.14 requantize into the result memory
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_mac_array import conv_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  tap_t              tap,
	input  pix_t              pix,
	input  pix_t              wgt  [`CONV_CHOUT],
	input  pix_t              bias [`CONV_CHOUT],
	input  logic [OUT_AW-1:0] out_adr,
	output pix_t              out_dat
);

	localparam int HI = `CONV_FRAC + `CONV_WIDTH; // first bit above the kept field

	acc_t             prod  [`CONV_CHOUT];
	acc_t             acc_q [`CONV_CHOUT];
	acc_t             sum   [`CONV_CHOUT];  // acc + bias in q4.28
	pix_t             res   [`CONV_CHOUT];
	pix_t             res_mem [OUT_WORDS];  // lane*9 + window
	logic             last_q;               // window closed in the previous cycle
	logic [IDX_W-1:0] idx_q;

	//////////////////////////////////////////////////
	// multiply and accumulate
	//////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < `CONV_CHOUT; l++)
			prod[l] = acc_t'(pix) * acc_t'(wgt[l]); // q2.14 * q2.14
	end

	always_ff @(posedge clk) begin
		if (tap.valid) begin
			for (int l = 0; l < `CONV_CHOUT; l++)
				acc_q[l] <= tap.first ? prod[l] : acc_q[l] + prod[l]; // restart per window
		end
		idx_q <= tap.out_idx;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			last_q <= 1'b0;
		else
			last_q <= tap.valid && tap.last;
	end

	//////////////////////////////////////////////////
	// bias, relu, requantize
	//////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < `CONV_CHOUT; l++) begin
			sum[l] = acc_q[l] + (acc_t'(bias[l]) <<< `CONV_FRAC);
			if (sum[l] < 0)
				res[l] = '0;                                   // relu
			else if (|sum[l][2*`CONV_WIDTH-1:HI])
				res[l] = pix_t'(16'h7fff);                     // too big for the field
			else
				res[l] = pix_t'(sum[l][HI-1:`CONV_FRAC]);
		end
	end

	// all four lanes land in the same cycle
	always_ff @(posedge clk) begin
		if (last_q) begin
			for (int l = 0; l < `CONV_CHOUT; l++)
				res_mem[l * OUT_PIX + idx_q] <= res[l];
		end
		out_dat <= (out_adr < OUT_WORDS) ? res_mem[out_adr] : '0; // registered bus read
	end

	// a window always has more than one tap
	first_not_last : assert property (@(posedge clk) disable iff (!arst_n)
		tap.valid |-> !(tap.first && tap.last));

endmodule

// ==== hw/conv_mem_bank.sv ====
// image ram, weight ram and bias registers; host writes from the bus, one synchronous compute read
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_mem_bank import conv_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              mem_we,
	input  mem_sel_e          mem_sel,
	input  logic [PIX_AW-1:0] mem_adr,
	input  pix_t              mem_dat,
	input  logic              busy,
	input  tap_t              tap_in,
	output tap_t              tap_out,
	output pix_t              pix,
	output pix_t              wgt  [`CONV_CHOUT],
	output pix_t              bias [`CONV_CHOUT]
);

	pix_t img_ram [IMG_WORDS];               // ch*64 + y*8 + x, padding included
	pix_t wgt_ram [`CONV_CHOUT][`CONV_TAPS]; // one bank per lane, all read at once
	pix_t bias_q  [`CONV_CHOUT];
	logic host_we;

	assign host_we = mem_we && !busy; // run owns the memories

	//////////////////////////////////////////////////
	// host write port
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (host_we) begin
			case (mem_sel)
				SEL_IMG: img_ram[mem_adr] <= mem_dat;
				SEL_WGT: begin
					// flat lane*18+tap address split into lane bank and tap
					for (int l = 0; l < `CONV_CHOUT; l++) begin
						if (mem_adr >= l * `CONV_TAPS && mem_adr < (l + 1) * `CONV_TAPS)
							wgt_ram[l][mem_adr - l * `CONV_TAPS] <= mem_dat;
					end
				end
				SEL_BIAS: bias_q[mem_adr[BIAS_AW-1:0]] <= mem_dat;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// compute read port, one cycle latency
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		pix <= img_ram[tap_in.pix_adr];
		for (int l = 0; l < `CONV_CHOUT; l++)
			wgt[l] <= wgt_ram[l][tap_in.wgt_adr]; // same tap in every lane
	end

	// tap markers travel beside the data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			tap_out <= '0;
		else
			tap_out <= tap_in;
	end

	assign bias = bias_q;

	// lane banks hold only 18 taps each
	wgt_in_range : assert property (@(posedge clk) disable iff (!arst_n)
		tap_in.valid |-> tap_in.wgt_adr < `CONV_TAPS);

endmodule

// ==== hw/conv_pkg.sv ====
// shared types and derived widths of the conv layer; modules pull them in with a wildcard import
`include "conv_defs.svh"

package conv_pkg;

	//////////////////////////////////////////////////
	// derived sizes
	//////////////////////////////////////////////////
	localparam int IMG_WORDS = `CONV_IMG_W * `CONV_IMG_W * `CONV_CHIN; // 128
	localparam int WGT_WORDS = `CONV_TAPS * `CONV_CHOUT;  // 72
	localparam int OUT_PIX   = `CONV_OUT_W * `CONV_OUT_W; // windows per lane
	localparam int OUT_WORDS = OUT_PIX * `CONV_CHOUT;     // 36
	localparam int PIX_AW    = $clog2(IMG_WORDS);         // 7
	localparam int WGT_AW    = $clog2(`CONV_TAPS);        // 5
	localparam int IDX_W     = $clog2(OUT_PIX);           // 4
	localparam int OUT_AW    = $clog2(OUT_WORDS);         // 6
	localparam int BIAS_AW   = $clog2(`CONV_CHOUT);
	localparam int KW        = $clog2(`CONV_KDIM);        // kx / ky counters
	localparam int CH_W      = (`CONV_CHIN > 1) ? $clog2(`CONV_CHIN) : 1;
	localparam int OW        = $clog2(`CONV_OUT_W);       // ox / oy counters
	localparam int WB_AW     = 10;
	localparam int WB_DW     = 32;

	typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} conv_state_e;

	// host write target
	typedef enum logic [1:0] {SEL_IMG, SEL_WGT, SEL_BIAS, SEL_NONE} mem_sel_e;

	typedef logic signed [`CONV_WIDTH-1:0]   pix_t;
	typedef logic signed [2*`CONV_WIDTH-1:0] acc_t;

	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr; // word address
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat; // valid with ack
	} wb_rsp_t;

	typedef struct packed {
		logic              valid;
		logic              first;   // first tap of a window
		logic              last;    // last tap of a window
		logic [PIX_AW-1:0] pix_adr;
		logic [WGT_AW-1:0] wgt_adr; // tap number inside a lane
		logic [IDX_W-1:0]  out_idx; // window number oy*3+ox
	} tap_t;

endpackage

// ==== hw/conv_wb_slave.sv ====
// wishbone classic slave of the conv layer, maps control, status, memories and results onto the bus
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_wb_slave import conv_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  wb_req_t           wb_req,
	output wb_rsp_t           wb_rsp,
	input  logic              busy,
	input  logic              done,
	output logic              start,
	output logic              mem_we,
	output mem_sel_e          mem_sel,
	output logic [PIX_AW-1:0] mem_adr,
	output pix_t              mem_dat,
	output logic [OUT_AW-1:0] out_adr,
	input  pix_t              out_dat
);

	logic             req;       // first cycle of a bus cycle
	logic             is_ctrl, is_stat, in_out;
	logic             ack_q;
	logic             rd_out_q;  // ack carries result memory data
	logic [WB_DW-1:0] ctrl_q;
	logic [WB_DW-1:0] rd_dat_q;

	assign req = wb_req.cyc && wb_req.stb && !ack_q;

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////
	assign is_ctrl = wb_req.adr == `CONV_ADR_CTRL;
	assign is_stat = wb_req.adr == `CONV_ADR_STAT;
	assign in_out  = wb_req.adr >= `CONV_ADR_OUT && wb_req.adr < `CONV_ADR_OUT + OUT_WORDS;

	always_comb begin
		mem_sel = SEL_NONE;
		mem_adr = '0;
		if (wb_req.adr >= `CONV_ADR_IMG && wb_req.adr < `CONV_ADR_IMG + IMG_WORDS) begin
			mem_sel = SEL_IMG;
			mem_adr = PIX_AW'(wb_req.adr - `CONV_ADR_IMG);
		end else if (wb_req.adr >= `CONV_ADR_WGT && wb_req.adr < `CONV_ADR_WGT + WGT_WORDS) begin
			mem_sel = SEL_WGT;
			mem_adr = PIX_AW'(wb_req.adr - `CONV_ADR_WGT); // lane*18 + tap
		end else if (wb_req.adr >= `CONV_ADR_BIAS && wb_req.adr < `CONV_ADR_BIAS + `CONV_CHOUT) begin
			mem_sel = SEL_BIAS;
			mem_adr = PIX_AW'(wb_req.adr - `CONV_ADR_BIAS);
		end
	end

	assign mem_we  = req && wb_req.we && mem_sel != SEL_NONE; // bank drops it while busy
	assign mem_dat = pix_t'(wb_req.dat[`CONV_WIDTH-1:0]);
	assign out_adr = OUT_AW'(wb_req.adr - `CONV_ADR_OUT);     // result ram reads while ack waits

	//////////////////////////////////////////////////
	// ack, control register, read select
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q    <= 1'b0;
			ctrl_q   <= '0;
			rd_out_q <= 1'b0;
		end else begin
			ack_q    <= req;                      // one cycle after stb, one cycle wide
			rd_out_q <= req && !wb_req.we && in_out;
			if (req && wb_req.we && is_ctrl)
				ctrl_q <= wb_req.dat;
			else
				ctrl_q[0] <= 1'b0;                // start bit clears itself
		end
	end

	assign start = ctrl_q[0];

	// ctrl and status readback, image and weight reads give zero
	always_ff @(posedge clk) begin
		if (req && !wb_req.we) begin
			if (is_stat)
				rd_dat_q <= {{(WB_DW-2){1'b0}}, done, busy};
			else if (is_ctrl)
				rd_dat_q <= ctrl_q;
			else
				rd_dat_q <= '0;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_out_q ? {{(WB_DW-`CONV_WIDTH){1'b0}}, out_dat} : rd_dat_q;

	// an ack only ever answers a live request
	ack_needs_req : assert property (@(posedge clk) disable iff (!arst_n)
		$rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb));

endmodule

// ==== hw/layer_ctrl_fsm.sv ====
// layer sequencer: idle, run over all windows, drain the mac pipeline, then flag done
`timescale 1ns/1ps
`include "conv_defs.svh"

module layer_ctrl_fsm import conv_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic scan_end,
	output logic cnt_en,
	output logic busy,
	output logic done
);

	localparam int DW = $clog2(`CONV_DRAIN);

	conv_state_e     state_q, state_d;
	logic [DW-1:0]   drain_q;          // cycles spent in DRAIN
	logic            drain_end;

	assign drain_end = drain_q == DW'(`CONV_DRAIN - 1);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE, DONE: if (start) state_d = RUN;      // restart allowed from DONE
			RUN: if (scan_end) state_d = DRAIN;         // last tap of window 8
			DRAIN: if (drain_end) state_d = DONE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			drain_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == DRAIN)
				drain_q <= drain_q + 1'b1;
			else
				drain_q <= '0;
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////
	assign cnt_en = state_q == RUN;
	assign busy   = state_q == RUN || state_q == DRAIN;
	assign done   = state_q == DONE; // holds until the next start

	// the scan only finishes while running
	scan_end_in_run : assert property (@(posedge clk) disable iff (!arst_n)
		scan_end |-> state_q == RUN);

endmodule

// ==== hw/window_tap_counter.sv ====
// walks every tap of every 3x3 window and produces pixel and weight addresses with window markers
`timescale 1ns/1ps
`include "conv_defs.svh"

module window_tap_counter import conv_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic cnt_en,
	output tap_t tap,
	output logic scan_end
);

	logic [KW-1:0]   kx_q, ky_q;
	logic [CH_W-1:0] ch_q;
	logic [OW-1:0]   ox_q, oy_q;
	logic            kx_end, ky_end, ch_end, ox_end, oy_end;
	logic [PIX_AW:0] pix_full;   // one spare bit for the range check

	assign kx_end = kx_q == KW'(`CONV_KDIM - 1);
	assign ky_end = ky_q == KW'(`CONV_KDIM - 1);
	assign ch_end = ch_q == CH_W'(`CONV_CHIN - 1);
	assign ox_end = ox_q == OW'(`CONV_OUT_W - 1);
	assign oy_end = oy_q == OW'(`CONV_OUT_W - 1);

	//////////////////////////////////////////////////
	// nested counters kx -> ky -> ch -> ox -> oy
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			kx_q <= '0;
			ky_q <= '0;
			ch_q <= '0;
			ox_q <= '0;
			oy_q <= '0;
		end else if (!cnt_en) begin // back to window 0 once the run stops
			kx_q <= '0;
			ky_q <= '0;
			ch_q <= '0;
			ox_q <= '0;
			oy_q <= '0;
		end else begin
			kx_q <= kx_end ? '0 : kx_q + 1'b1;
			if (kx_end) begin
				ky_q <= ky_end ? '0 : ky_q + 1'b1;
				if (ky_end) begin
					ch_q <= ch_end ? '0 : ch_q + 1'b1;
					if (ch_end) begin                  // window finished
						ox_q <= ox_end ? '0 : ox_q + 1'b1;
						if (ox_end)
							oy_q <= oy_end ? '0 : oy_q + 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// addresses and markers
	//////////////////////////////////////////////////
	// ch*64 + (oy*2+ky)*8 + ox*2+kx
	assign pix_full = (PIX_AW + 1)'(ch_q * `CONV_IMG_W * `CONV_IMG_W
		+ (oy_q * `CONV_STRIDE + ky_q) * `CONV_IMG_W
		+ ox_q * `CONV_STRIDE + kx_q);

	always_comb begin
		tap.valid   = cnt_en;
		tap.first   = kx_q == '0 && ky_q == '0 && ch_q == '0;
		tap.last    = kx_end && ky_end && ch_end;
		tap.pix_adr = pix_full[PIX_AW-1:0];
		tap.wgt_adr = WGT_AW'(ch_q * `CONV_KDIM * `CONV_KDIM + ky_q * `CONV_KDIM + kx_q);
		tap.out_idx = IDX_W'(oy_q * `CONV_OUT_W + ox_q);
	end

	assign scan_end = tap.valid && tap.last && ox_end && oy_end; // last tap of window 8

	// window never reaches past the padded image
	pix_in_range : assert property (@(posedge clk) disable iff (!arst_n)
		tap.valid |-> pix_full < IMG_WORDS);

endmodule

// ==== include/conv_defs.svh ====
// conv layer geometry, fixed-point format and wishbone word map; include before conv_pkg is compiled
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

//////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////
`define CONV_IMG_W    8     // padded width == height, border already zero
`define CONV_CHIN     2     // input channels
`define CONV_CHOUT    4     // output channels, one mac lane each
`define CONV_KDIM     3     // kernel width == height
`define CONV_STRIDE   2
`define CONV_OUT_W    3     // output width == height
`define CONV_TAPS     18    // kdim*kdim*chin taps per window

//////////////////////////////////////////////////
// number format and pipeline
//////////////////////////////////////////////////
`define CONV_WIDTH    16    // data word
`define CONV_FRAC     14    // q2.14
`define CONV_DRAIN    3     // cycles after the last tap until results are stored

//////////////////////////////////////////////////
// wishbone word addresses
//////////////////////////////////////////////////
`define CONV_ADR_CTRL 10'h000   // bit 0 start
`define CONV_ADR_STAT 10'h001   // bit 0 busy, bit 1 done
`define CONV_ADR_IMG  10'h040   // 128 words, ch*64 + y*8 + x
`define CONV_ADR_WGT  10'h100   // 72 words, lane*18 + tap
`define CONV_ADR_BIAS 10'h160   // 4 words
`define CONV_ADR_OUT  10'h180   // 36 words, lane*9 + oy*3 + ox

`endif
